/* Makefile */
# Verilator simulation of the execute unit

TOP = exec_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fails unless the run passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* alu.sv */
////////////////////////////////////////
// Integer ALU, result held in a register
// Shift amount is i_b[4:0] whatever the width
// SLT compares signed
////////////////////////////////////////
`default_nettype none

module alu
    import exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   i_rst,
    input  alu_op_e               i_op,
    input  wire  [DATA_WIDTH-1:0] i_a,
    input  wire  [DATA_WIDTH-1:0] i_b,
    input  wire                   i_load,    // Capture strobe from the controller
    output logic [DATA_WIDTH-1:0] o_result
);

    logic [DATA_WIDTH-1:0] result_d;
    logic [4:0]            shamt;
    logic                  lt;

    assign shamt = i_b[4:0];                 // Low five bits only
    assign lt    = $signed(i_a) < $signed(i_b);

    // Operation select
    always_comb begin
        case (i_op)
            ALU_ADD: result_d = i_a + i_b;
            ALU_SUB: result_d = i_a - i_b;
            ALU_AND: result_d = i_a & i_b;
            ALU_OR:  result_d = i_a | i_b;
            ALU_XOR: result_d = i_a ^ i_b;
            ALU_SLT: begin
                result_d = '0;
                result_d[0] = lt;            // 0 or 1
            end
            ALU_SLL: result_d = i_a << shamt;
            ALU_SRL: result_d = i_a >> shamt; // Logical, zero fill
            default: result_d = '0;
        endcase
    end

    // Result register, updated only on load
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_result <= '0;
        end else if (i_load) begin
            o_result <= result_d;
        end
    end

endmodule

`default_nettype wire

/* credit_counter.sv */
////////////////////////////////////////
// Consumer slot counter, starts full
// Returns must never exceed records sent
////////////////////////////////////////
`default_nettype none

module credit_counter #(
    parameter int WB_CREDITS = 4
) (
    input  wire  clk,
    input  wire  i_rst,
    input  wire  i_credit_return,   // One slot freed
    input  wire  i_credit_use,      // One record sent
    output logic o_has_credit
);

    localparam int CNT_W = $clog2(WB_CREDITS + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            count_q <= CNT_W'(WB_CREDITS);   // All slots free
        end else begin
            case ({i_credit_use, i_credit_return})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    assign o_has_credit = (count_q != '0);

endmodule

`default_nettype wire

/* exec_ctrl.sv */
////////////////////////////////////////
// Execute controller, one instruction in flight
// Idle -> execute -> send; waits in send for a credit
// Illegal records carry rd = x0 so nothing is written
// Needs DATA_WIDTH >= 12 for the immediate
////////////////////////////////////////
`default_nettype none

module exec_ctrl
    import exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   i_rst,
    input  wire                   i_in_valid,
    input  instr_u                i_in_instr,
    input  wire                   i_has_credit,  // Consumer has a free slot
    input  wire  [DATA_WIDTH-1:0] i_rs1_data,
    input  wire  [DATA_WIDTH-1:0] i_rs2_data,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output alu_op_e               o_alu_op,
    output logic [DATA_WIDTH-1:0] o_alu_a,
    output logic [DATA_WIDTH-1:0] o_alu_b,
    output logic                  o_alu_load,
    output logic                  o_send,        // Record valid, wen, input credit
    output logic [REG_ADDR_W-1:0] o_wb_rd,
    output logic                  o_wb_illegal
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_SEND
    } state_e;

    state_e                state_q;
    instr_u                instr_q;          // Current instruction word
    logic                  illegal_q;
    logic [REG_ADDR_W-1:0] wb_rd_q;
    logic                  illegal_d;
    logic                  use_imm;
    logic [DATA_WIDTH-1:0] imm_ext;

    // Decode through the R view, immediate through the I view
    always_comb begin
        o_alu_op  = ALU_ADD;
        illegal_d = 1'b0;
        use_imm   = 1'b0;
        case (instr_q.r.opcode)
            OPC_OP: begin
                case (instr_q.r.funct3)
                    F3_ADD_SUB: o_alu_op = (instr_q.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     o_alu_op = ALU_SLL;
                    F3_SLT:     o_alu_op = ALU_SLT;
                    F3_XOR:     o_alu_op = ALU_XOR;
                    F3_SRL:     o_alu_op = ALU_SRL;
                    F3_OR:      o_alu_op = ALU_OR;
                    F3_AND:     o_alu_op = ALU_AND;
                    default:    illegal_d = 1'b1;   // SLTU
                endcase
                // Only SUB may use the alternate funct7
                if (instr_q.r.funct7 != '0 &&
                    !(instr_q.r.funct7 == F7_ALT && instr_q.r.funct3 == F3_ADD_SUB)) begin
                    illegal_d = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (instr_q.i.funct3)
                    F3_ADD_SUB: o_alu_op = ALU_ADD;     // ADDI
                    F3_SLT:     o_alu_op = ALU_SLT;
                    F3_XOR:     o_alu_op = ALU_XOR;
                    F3_OR:      o_alu_op = ALU_OR;
                    F3_AND:     o_alu_op = ALU_AND;
                    default:    illegal_d = 1'b1;   // Immediate shifts, SLTIU
                endcase
            end
            default: illegal_d = 1'b1;
        endcase
    end

    // Operand steering
    assign imm_ext    = {{(DATA_WIDTH-12){instr_q.i.imm[11]}}, instr_q.i.imm};
    assign o_rs1_addr = instr_q.r.rs1;
    assign o_rs2_addr = instr_q.r.rs2;       // Ignored for I-type
    assign o_alu_a    = i_rs1_data;
    assign o_alu_b    = use_imm ? imm_ext : i_rs2_data;

    assign o_alu_load   = (state_q == ST_EXEC);
    assign o_send       = (state_q == ST_SEND) && i_has_credit;
    assign o_wb_rd      = wb_rd_q;
    assign o_wb_illegal = illegal_q;

    // Sequencing
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q   <= ST_IDLE;
            illegal_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (i_in_valid) state_q <= ST_EXEC;
                ST_EXEC: begin
                    illegal_q <= illegal_d;
                    state_q   <= ST_SEND;
                end
                ST_SEND: if (i_has_credit) state_q <= ST_IDLE;  // Record leaves
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_in_valid) begin
            instr_q <= i_in_instr;
        end
        if (state_q == ST_EXEC) begin
            wb_rd_q <= illegal_d ? '0 : instr_q.r.rd;  // Steer illegal to x0
        end
    end

endmodule

`default_nettype wire

/* exec_pkg.sv */
////////////////////////////////////////
// Shared definitions for the execute unit
// RV32I subset only: OP and OP-IMM majors
// Instruction word is a packed union, R and I views
////////////////////////////////////////
`default_nettype none

package exec_pkg;

    // Register address width, 32 entries
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // R-type ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // I-type ALU

    // funct3 codes, shared by R and I forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;      // SRA shares this code, not supported
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 alternate encoding, selects SUB
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,                              // Signed compare
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_e;

    // Register-register layout
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    // Register-immediate layout
    typedef struct packed {
        logic signed [11:0]    imm;                  // Sign-extended by the controller
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    // One 32-bit word, decoded either way by opcode
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

`default_nettype wire

/* exec_unit_assert.sv */
////////////////////////////////////////
// Protocol checker bound into exec_unit_top
// Assumes the sender holds a single credit
// Consumer returns never exceed records sent
////////////////////////////////////////
`default_nettype none

module exec_unit_assert #(
    parameter int WB_CREDITS = 4
) (
    input wire clk,
    input wire i_rst,
    input wire i_in_valid,
    input wire i_in_credit,     // DUT o_in_credit
    input wire i_wb_valid,      // DUT o_wb_valid
    input wire i_wb_illegal,
    input wire i_wb_credit,
    input wire i_has_credit     // Counter status inside the top
);

    int   outstanding;          // Records held by the consumer
    logic sender_credit;
    int   fail_count = 0;       // Failed assertions so far

    always_ff @(posedge clk) begin
        if (i_rst) begin
            outstanding   <= 0;
            sender_credit <= 1'b1;  // Sender starts with one
        end else begin
            outstanding <= outstanding + (i_wb_valid ? 1 : 0) - (i_wb_credit ? 1 : 0);
            if (i_in_valid) begin
                sender_credit <= 1'b0;
            end else if (i_in_credit) begin
                sender_credit <= 1'b1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        i_rst |=> (!i_wb_valid && !i_in_credit && !i_wb_illegal))
        else begin
            $error("Record or credit active right after reset");
            fail_count++;
        end

    a_credit_mirror: assert property (@(posedge clk) disable iff (i_rst)
        i_in_credit == i_wb_valid)
        else begin
            $error("Input credit pulse differs from record valid");
            fail_count++;
        end

    a_slots_bounded: assert property (@(posedge clk) disable iff (i_rst)
        outstanding <= WB_CREDITS)
        else begin
            $error("More records outstanding than consumer slots");
            fail_count++;
        end

    a_no_send_full: assert property (@(posedge clk) disable iff (i_rst)
        i_wb_valid |-> (outstanding < WB_CREDITS))
        else begin
            $error("Record sent with no consumer credit left");
            fail_count++;
        end

    a_exec_gap: assert property (@(posedge clk) disable iff (i_rst)
        $past(i_in_valid) |-> !i_wb_valid)
        else begin
            $error("Record one cycle after acceptance");
            fail_count++;
        end

    a_latency: assert property (@(posedge clk) disable iff (i_rst)
        $past(i_in_valid, 2) |-> (i_wb_valid == i_has_credit))
        else begin
            $error("Record not sent two cycles after acceptance");
            fail_count++;
        end

    a_one_in_flight: assert property (@(posedge clk) disable iff (i_rst)
        i_in_valid |-> sender_credit)
        else begin
            $error("Instruction issued before its credit came back");
            fail_count++;
        end

    a_no_extra_credit: assert property (@(posedge clk) disable iff (i_rst)
        i_in_credit |-> !sender_credit)
        else begin
            $error("Input credit returned while sender already holds it");
            fail_count++;
        end

endmodule

`default_nettype wire

/* exec_unit_tb.sv */
////////////////////////////////////////
// Testbench for exec_unit_top, DATA_WIDTH 32
// Inputs driven 1 after the rising edge
// Records sampled at the falling edge
// Consumer returns credits after random delays
////////////////////////////////////////
`default_nettype none

module exec_unit_tb
    import exec_pkg::*;
();

    localparam int          WB_CREDITS = 4;
    localparam int          N_RAND     = 200;
    localparam int          N_DIRECTED = 50;     // Bound on directed instructions
    localparam int          TIMEOUT    = (N_RAND + N_DIRECTED) * 20 * 10;
    localparam logic [31:0] SEED       = 32'h1acd;

    logic                  clk;
    logic                  i_rst;
    logic                  i_in_valid;
    instr_u                i_in_instr;
    logic                  o_in_credit;
    logic                  o_wb_valid;
    logic [REG_ADDR_W-1:0] o_wb_rd;
    logic [31:0]           o_wb_data;
    logic                  o_wb_illegal;
    logic                  i_wb_credit;

    logic [31:0] regs_model [32];
    logic [4:0]  in_credits;                     // Sender side credit
    logic [31:0] rng;
    logic        withhold;                       // Consumer keeps its slots
    int          held;                           // Records in consumer buffer
    int          errors;
    int          checks;

    tb_clock #(.PERIOD(10)) u_clk (.o_clk(clk));

    exec_unit_top #(
        .DATA_WIDTH (32),
        .WB_CREDITS (WB_CREDITS)
    ) uut (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_in_valid   (i_in_valid),
        .i_in_instr   (i_in_instr),
        .o_in_credit  (o_in_credit),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_wb_illegal (o_wb_illegal),
        .i_wb_credit  (i_wb_credit)
    );

    bind exec_unit_top exec_unit_assert #(.WB_CREDITS(WB_CREDITS)) u_assert (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_in_valid   (i_in_valid),
        .i_in_credit  (o_in_credit),
        .i_wb_valid   (o_wb_valid),
        .i_wb_illegal (o_wb_illegal),
        .i_wb_credit  (i_wb_credit),
        .i_has_credit (has_credit)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Reference ALU, index k: add sub and or xor slt sll srl
    function automatic logic [31:0] expected(input int k, input logic [31:0] a,
                                             input logic [31:0] b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return a << b[4:0];               // Low five bits only
            default: return a >> b[4:0];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic send_instr(input instr_u w);
        @(posedge clk);
        #1;
        checks++;
        assert (in_credits != 5'd0) else begin
            errors++;
            $display("Sender has no input credit left to issue with");
        end
        in_credits = in_credits - 5'd1;
        i_in_valid = 1'b1;
        i_in_instr = w;
        @(posedge clk);
        #1;
        i_in_valid = 1'b0;                       // Single valid cycle
    endtask

    task automatic wait_record(input logic [4:0] rd, input logic [31:0] data,
                               input logic illegal);
        @(negedge clk);
        while (!o_wb_valid) @(negedge clk);
        check_value("o_wb_illegal", 32'(o_wb_illegal), 32'(illegal));
        check_value("o_wb_rd", 32'(o_wb_rd), 32'(rd));  // Illegal goes to x0
        if (!illegal) begin
            check_value("o_wb_data", o_wb_data, data);
            if (rd != 5'd0) regs_model[rd] = data;
        end
        if (o_in_credit) in_credits = in_credits + 5'd1;
    endtask

    // Encode one supported instruction, predict its result from the model
    task automatic build_legal(input logic imm_form, input int k, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [11:0] imm, output instr_u w,
                               output logic [31:0] res);
        logic [31:0] b;
        w       = '0;
        w.r.rd  = rd;
        w.r.rs1 = rs1;
        case (k)
            2: w.r.funct3 = F3_AND;
            3: w.r.funct3 = F3_OR;
            4: w.r.funct3 = F3_XOR;
            5: w.r.funct3 = F3_SLT;
            6: w.r.funct3 = F3_SLL;
            7: w.r.funct3 = F3_SRL;
            default: w.r.funct3 = F3_ADD_SUB;
        endcase
        if (imm_form) begin
            w.i.opcode = OPC_OP_IMM;
            w.i.imm    = imm;
            b = {{20{imm[11]}}, imm};            // Sign extend
        end else begin
            w.r.opcode = OPC_OP;
            w.r.rs2    = rs2;
            w.r.funct7 = (k == 1) ? F7_ALT : 7'd0;
            b = regs_model[rs2];
        end
        res = expected(k, regs_model[rs1], b);
    endtask

    task automatic run_legal(input logic imm_form, input int k, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [11:0] imm);
        instr_u      w;
        logic [31:0] res;
        build_legal(imm_form, k, rd, rs1, rs2, imm, w, res);
        send_instr(w);
        wait_record(rd, res, 1'b0);
    endtask

    task automatic run_illegal(input int kind, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2);
        instr_u w;
        w          = '0;
        w.r.opcode = OPC_OP;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        case (kind)
            0: w.r.opcode = 7'b0000011;          // Load major
            1: w.r.funct3 = 3'b011;              // SLTU
            2: begin
                w.r.funct7 = F7_ALT;             // Alternate funct7 on XOR
                w.r.funct3 = F3_XOR;
            end
            default: begin
                w.r.opcode = OPC_OP_IMM;         // SLLI
                w.r.funct3 = F3_SLL;
            end
        endcase
        send_instr(w);
        wait_record(5'd0, 32'd0, 1'b1);
    endtask

    task automatic report_and_finish(input logic timed_out);
        int total;
        total = errors + uut.u_assert.fail_count + (timed_out ? 1 : 0);
        $display("Checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // Main stimulus
    initial begin
        int          r;
        int          k;
        logic [4:0]  rd;
        instr_u      w;
        logic [31:0] res;
        i_rst      = 1'b1;
        i_in_valid = 1'b0;
        i_in_instr = '0;
        withhold   = 1'b0;
        errors     = 0;
        checks     = 0;
        in_credits = 5'd1;
        rng        = SEED;
        for (int n = 0; n < 32; n++) regs_model[n] = '0;
        repeat (2) @(posedge clk);
        #1;
        i_rst = 1'b0;

        run_legal(1'b0, 0, 5'd7, 5'd12, 5'd30, 12'd0);    // All zero before writes
        for (int n = 1; n < 32; n++) begin                // Seed every register
            rng = xorshift(rng);
            run_legal(1'b1, 0, 5'(n), 5'(n - 1), 5'd0, rng[11:0]);
        end

        // x0 as destination keeps reading zero
        run_legal(1'b1, 4, 5'd0, 5'd9, 5'd0, 12'h5a5);
        run_legal(1'b0, 3, 5'd0, 5'd3, 5'd17, 12'd0);
        run_legal(1'b0, 3, 5'd21, 5'd0, 5'd0, 12'd0);

        for (int n = 0; n < 4; n++) begin
            rng = xorshift(rng);
            rd  = rng[4:0] | 5'd1;
            run_illegal(n, rd, rng[9:5], rng[14:10]);
            run_legal(1'b1, 3, 5'd2, rd, 5'd0, 12'd0);    // ORI reads rd back
        end

        // Drain, then fill every consumer slot
        @(posedge clk);
        #2;
        while (held != 0) begin
            @(posedge clk);
            #2;
        end
        withhold = 1'b1;
        for (int n = 0; n < WB_CREDITS; n++) begin
            run_legal(1'b0, 0, 5'(n + 1), 5'(n + 1), 5'd31, 12'd0);
        end
        build_legal(1'b0, 1, 5'd10, 5'd11, 5'd12, 12'd0, w, res);
        send_instr(w);
        repeat (12) begin
            @(negedge clk);
            check_value("o_wb_valid", 32'(o_wb_valid), 32'd0);   // Stalled
        end
        withhold = 1'b0;
        wait_record(5'd10, res, 1'b0);

        for (int n = 0; n < N_RAND; n++) begin
            rng = xorshift(rng);
            r   = int'(rng % 32'd13);            // 0-7 R ops, 8-12 I ops
            k   = (r < 8) ? r : ((r == 8) ? 0 : r - 7);
            run_legal(r >= 8, k, rng[8:4], rng[13:9], rng[18:14], rng[30:19]);
        end
        report_and_finish(1'b0);
    end

    // Consumer, frees one slot per credit pulse
    initial begin
        logic [31:0] crng;
        int          delay;
        crng        = {SEED[15:0], SEED[31:16]};
        delay       = 0;
        held        = 0;
        i_wb_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (o_wb_valid) held++;
            @(posedge clk);
            #1;
            i_wb_credit = 1'b0;
            if (held > 0 && !withhold) begin
                if (delay == 0) begin
                    i_wb_credit = 1'b1;
                    held--;
                    crng  = xorshift(crng);
                    delay = (crng[2:0] == 3'd0) ? 8 + int'(crng[7:4]) : int'(crng[5:4]);
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired after %0d time units, DUT stopped responding", TIMEOUT);
        report_and_finish(1'b1);
    end

endmodule

`default_nettype wire

/* exec_unit_top.sv */
////////////////////////////////////////
// Execute unit top, wiring only
// Sender holds one credit, back on o_in_credit
// o_wb_valid, o_in_credit and regfile write
// are the same send strobe
////////////////////////////////////////
`default_nettype none

module exec_unit_top
    import exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int WB_CREDITS = 4
) (
    input  wire                   clk,
    input  wire                   i_rst,
    input  wire                   i_in_valid,
    input  instr_u                i_in_instr,
    output logic                  o_in_credit,
    output logic                  o_wb_valid,
    output logic [REG_ADDR_W-1:0] o_wb_rd,
    output logic [DATA_WIDTH-1:0] o_wb_data,
    output logic                  o_wb_illegal,
    input  wire                   i_wb_credit
);

    logic                  send;
    logic                  has_credit;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_WIDTH-1:0] rs1_data;
    logic [DATA_WIDTH-1:0] rs2_data;
    logic [DATA_WIDTH-1:0] alu_a;
    logic [DATA_WIDTH-1:0] alu_b;
    logic                  alu_load;
    alu_op_e               alu_op;

    exec_ctrl #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_in_valid   (i_in_valid),
        .i_in_instr   (i_in_instr),
        .i_has_credit (has_credit),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_alu_op     (alu_op),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .o_alu_load   (alu_load),
        .o_send       (send),
        .o_wb_rd      (o_wb_rd),
        .o_wb_illegal (o_wb_illegal)
    );

    credit_counter #(
        .WB_CREDITS (WB_CREDITS)
    ) u_credits (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_credit_return (i_wb_credit),
        .i_credit_use    (send),
        .o_has_credit    (has_credit)
    );

    regfile #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_regfile (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_addr1 (rs1_addr),
        .i_addr2 (rs2_addr),
        .i_waddr (o_wb_rd),      // x0 for illegal records
        .i_wdata (o_wb_data),
        .i_wen   (send),
        .o_dout1 (rs1_data),
        .o_dout2 (rs2_data)
    );

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_op     (alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_load   (alu_load),
        .o_result (o_wb_data)
    );

    assign o_wb_valid  = send;
    assign o_in_credit = send;   // Retire frees the sender's credit

endmodule

`default_nettype wire

/* files.f */
exec_pkg.sv
regfile.sv
alu.sv
exec_ctrl.sv
credit_counter.sv
exec_unit_top.sv
tb_clock.sv
exec_unit_assert.sv
exec_unit_tb.sv

/* regfile.sv */
////////////////////////////////////////
// 32 x DATA_WIDTH register file
// Reads are combinational, x0 reads zero
// Writes to x0 dropped, sync reset clears all
////////////////////////////////////////
`default_nettype none

module regfile
    import exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   i_rst,
    input  wire  [REG_ADDR_W-1:0] i_addr1,   // Read port 1 address
    input  wire  [REG_ADDR_W-1:0] i_addr2,   // Read port 2 address
    input  wire  [REG_ADDR_W-1:0] i_waddr,
    input  wire  [DATA_WIDTH-1:0] i_wdata,
    input  wire                   i_wen,     // Already qualified by the controller
    output logic [DATA_WIDTH-1:0] o_dout1,
    output logic [DATA_WIDTH-1:0] o_dout2
);

    localparam int DEPTH = 1 << REG_ADDR_W;

    logic [DATA_WIDTH-1:0] regs [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < DEPTH; k++) begin
                regs[k] <= '0;
            end
        end else if (i_wen && (i_waddr != '0)) begin  // x0 never written
            regs[i_waddr] <= i_wdata;
        end
    end

    // Read port 1
    always_comb begin
        if (i_addr1 == '0) begin
            o_dout1 = '0;                     // Hardwired zero
        end else begin
            o_dout1 = regs[i_addr1];
        end
    end

    // Read port 2
    always_comb begin
        if (i_addr2 == '0) begin
            o_dout2 = '0;
        end else begin
            o_dout2 = regs[i_addr2];
        end
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
////////////////////////////////////////
// Free-running testbench clock
// Starts low, first rising edge at PERIOD/2
////////////////////////////////////////
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;   // 50% duty
    end

endmodule

`default_nettype wire
